/* hw/soc_mem_pkg.sv */
// ---------------------------------------------------------------------
// soc_mem_pkg: bus widths, data types and controller states shared
// by the caches, the AXI arbiter and the testbench
// ---------------------------------------------------------------------
package soc_mem_pkg;

    parameter int ADDR_W  = 64;
    parameter int DATA_W  = 64;
    parameter int STRB_W  = DATA_W / 8;
    parameter int ID_W    = 4;
    parameter int LEN_W   = 8;
    parameter int SIZE_W  = 3;
    parameter int BURST_W = 2;
    parameter int RESP_W  = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   axi_id_t;

    // transaction ids per requester
    localparam axi_id_t ID_ICACHE = 4'd0;
    localparam axi_id_t ID_DCACHE = 4'd1;

    // every transfer is one 8-byte beat
    localparam logic [SIZE_W-1:0]  AXI_SIZE_8B    = 3'd3;
    localparam logic [BURST_W-1:0] AXI_BURST_INCR = 2'b01;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_WRITE_WAIT
    } cache_state_e;

    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_READ_ADDR,
        ARB_READ_DATA,
        ARB_WRITE_REQ,
        ARB_WRITE_RESP
    } arb_state_e;

endpackage

/* hw/icache.sv */
// ---------------------------------------------------------------------
// icache: direct-mapped read-only instruction cache, one 64-bit word
// per line, misses become single-word fill requests
// ---------------------------------------------------------------------
module icache
    import soc_mem_pkg::*;
#(
    parameter int LINES = 16
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_inst_ena,
    input  addr_t i_inst_addr,
    input  data_t i_fill_data,
    input  logic  i_fill_ok,
    output logic  o_inst_valid,
    output data_t o_inst_data,
    output logic  o_fill_req,
    output addr_t o_fill_addr
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = ADDR_W - 3 - IDX_W;

    cache_state_e     state;
    addr_t            req_addr;
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_mem [LINES];
    data_t            data_mem [LINES];

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    logic             accept;

    assign req_idx = req_addr[3 +: IDX_W];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
    assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    // the cpu still holds the old address during the valid pulse
    assign accept = (state == ST_IDLE) && i_inst_ena && !o_inst_valid;

    assign o_fill_req  = (state == ST_FILL);
    assign o_fill_addr = {req_addr[ADDR_W-1:3], 3'b000};

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state        <= ST_IDLE;
            valid_q      <= '0;
            o_inst_valid <= 1'b0;
        end else begin
            o_inst_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        o_inst_valid <= 1'b1;
                        state        <= ST_IDLE;
                    end else begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (i_fill_ok) begin
                        valid_q[req_idx] <= 1'b1;
                        o_inst_valid     <= 1'b1;
                        state            <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // arrays and returned word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= i_inst_addr;
        end
        if (state == ST_LOOKUP && hit) begin
            o_inst_data <= data_mem[req_idx];
        end
        if (state == ST_FILL && i_fill_ok) begin
            tag_mem[req_idx]  <= req_tag;
            data_mem[req_idx] <= i_fill_data;
            o_inst_data       <= i_fill_data;
        end
    end

endmodule

/* hw/dcache.sv */
// ---------------------------------------------------------------------
// dcache: direct-mapped write-through data cache; write hits merge
// into the cached word under the byte mask, write misses skip it
// ---------------------------------------------------------------------
module dcache
    import soc_mem_pkg::*;
#(
    parameter int LINES = 16
) (
    input  logic  clk,
    input  logic  i_rst_n,
    input  logic  i_re,
    input  logic  i_we,
    input  addr_t i_addr,
    input  data_t i_wdata,
    input  strb_t i_wmask,
    input  data_t i_mem_rdata,
    input  logic  i_mem_ok,
    output data_t o_rdata,
    output logic  o_finish,
    output logic  o_mem_rd_req,
    output logic  o_mem_wr_req,
    output addr_t o_mem_addr,
    output data_t o_mem_wdata,
    output strb_t o_mem_wstrb
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = ADDR_W - 3 - IDX_W;

    cache_state_e     state;
    addr_t            req_addr;
    data_t            req_wdata;
    strb_t            req_wmask;
    logic             req_we;
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_mem [LINES];
    data_t            data_mem [LINES];

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    logic             accept;
    data_t            merged;

    assign req_idx = req_addr[3 +: IDX_W];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
    assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign accept  = (state == ST_IDLE) && (i_re || i_we) && !o_finish;

    assign o_mem_rd_req = (state == ST_FILL);
    assign o_mem_wr_req = (state == ST_WRITE_WAIT);
    assign o_mem_addr   = {req_addr[ADDR_W-1:3], 3'b000};
    assign o_mem_wdata  = req_wdata;
    assign o_mem_wstrb  = req_wmask;

    // cached word with the store bytes laid over it
    always_comb begin
        merged = data_mem[req_idx];
        for (int b = 0; b < STRB_W; b++) begin
            if (req_wmask[b]) begin
                merged[b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            valid_q  <= '0;
            o_finish <= 1'b0;
        end else begin
            o_finish <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (req_we) begin
                        state <= ST_WRITE_WAIT;
                    end else if (hit) begin
                        o_finish <= 1'b1;
                        state    <= ST_IDLE;
                    end else begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (i_mem_ok) begin
                        valid_q[req_idx] <= 1'b1;
                        o_finish         <= 1'b1;
                        state            <= ST_IDLE;
                    end
                end
                ST_WRITE_WAIT: begin
                    if (i_mem_ok) begin
                        o_finish <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
            req_wmask <= i_wmask;
            req_we    <= i_we;
        end
        if (state == ST_LOOKUP && hit) begin
            if (req_we) begin
                data_mem[req_idx] <= merged;
            end else begin
                o_rdata <= data_mem[req_idx];
            end
        end
        if (state == ST_FILL && i_mem_ok) begin
            tag_mem[req_idx]  <= req_tag;
            data_mem[req_idx] <= i_mem_rdata;
            o_rdata           <= i_mem_rdata;
        end
    end

endmodule

/* hw/mem_arbiter.sv */
// ---------------------------------------------------------------------
// mem_arbiter: shares one AXI4 master between the two caches, one
// single-beat transaction at a time, data cache first
// ---------------------------------------------------------------------
module mem_arbiter
    import soc_mem_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_ic_req,
    input  addr_t              i_ic_addr,
    output data_t              o_ic_rdata,
    output logic               o_ic_ok,
    input  logic               i_dc_rd_req,
    input  logic               i_dc_wr_req,
    input  addr_t              i_dc_addr,
    input  data_t              i_dc_wdata,
    input  strb_t              i_dc_wstrb,
    output data_t              o_dc_rdata,
    output logic               o_dc_ok,
    output axi_id_t            o_axi_aw_id,
    output addr_t              o_axi_aw_addr,
    output logic [LEN_W-1:0]   o_axi_aw_len,
    output logic [SIZE_W-1:0]  o_axi_aw_size,
    output logic [BURST_W-1:0] o_axi_aw_burst,
    output logic               o_axi_aw_valid,
    input  logic               i_axi_aw_ready,
    output data_t              o_axi_w_data,
    output strb_t              o_axi_w_strb,
    output logic               o_axi_w_last,
    output logic               o_axi_w_valid,
    input  logic               i_axi_w_ready,
    input  axi_id_t            i_axi_b_id,
    input  logic [RESP_W-1:0]  i_axi_b_resp,
    input  logic               i_axi_b_valid,
    output logic               o_axi_b_ready,
    output axi_id_t            o_axi_ar_id,
    output addr_t              o_axi_ar_addr,
    output logic [LEN_W-1:0]   o_axi_ar_len,
    output logic [SIZE_W-1:0]  o_axi_ar_size,
    output logic [BURST_W-1:0] o_axi_ar_burst,
    output logic               o_axi_ar_valid,
    input  logic               i_axi_ar_ready,
    input  axi_id_t            i_axi_r_id,
    input  data_t              i_axi_r_data,
    input  logic [RESP_W-1:0]  i_axi_r_resp,
    input  logic               i_axi_r_last,
    input  logic               i_axi_r_valid,
    output logic               o_axi_r_ready
);

    arb_state_e state;
    addr_t      req_addr;
    data_t      req_wdata;
    strb_t      req_wstrb;
    axi_id_t    req_id;
    data_t      rsp_data;
    logic       aw_pend;
    logic       w_pend;
    logic       grant;
    logic       dc_sel;
    logic       aw_done;
    logic       w_done;

    // no new grant while the ok pulse is out, the requester still holds
    assign grant   = (state == ARB_IDLE) && !(o_ic_ok || o_dc_ok);
    assign dc_sel  = i_dc_rd_req || i_dc_wr_req;
    assign aw_done = !aw_pend || i_axi_aw_ready;
    assign w_done  = !w_pend || i_axi_w_ready;

    assign o_axi_ar_id    = req_id;
    assign o_axi_ar_addr  = req_addr;
    assign o_axi_ar_len   = '0;
    assign o_axi_ar_size  = AXI_SIZE_8B;
    assign o_axi_ar_burst = AXI_BURST_INCR;
    assign o_axi_ar_valid = (state == ARB_READ_ADDR);
    assign o_axi_r_ready  = (state == ARB_READ_DATA);

    assign o_axi_aw_id    = req_id;
    assign o_axi_aw_addr  = req_addr;
    assign o_axi_aw_len   = '0;
    assign o_axi_aw_size  = AXI_SIZE_8B;
    assign o_axi_aw_burst = AXI_BURST_INCR;
    assign o_axi_aw_valid = (state == ARB_WRITE_REQ) && aw_pend;
    assign o_axi_w_data   = req_wdata;
    assign o_axi_w_strb   = req_wstrb;
    assign o_axi_w_last   = 1'b1;
    assign o_axi_w_valid  = (state == ARB_WRITE_REQ) && w_pend;
    assign o_axi_b_ready  = (state == ARB_WRITE_RESP);

    assign o_ic_rdata = rsp_data;
    assign o_dc_rdata = rsp_data;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state   <= ARB_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            o_ic_ok <= 1'b0;
            o_dc_ok <= 1'b0;
        end else begin
            o_ic_ok <= 1'b0;
            o_dc_ok <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (grant && i_dc_wr_req) begin
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                        state   <= ARB_WRITE_REQ;
                    end else if (grant && (i_dc_rd_req || i_ic_req)) begin
                        state <= ARB_READ_ADDR;
                    end
                end
                ARB_READ_ADDR: begin
                    if (i_axi_ar_ready) begin
                        state <= ARB_READ_DATA;
                    end
                end
                ARB_READ_DATA: begin
                    if (i_axi_r_valid && i_axi_r_last) begin
                        o_ic_ok <= (req_id == ID_ICACHE);
                        o_dc_ok <= (req_id == ID_DCACHE);
                        state   <= ARB_IDLE;
                    end
                end
                ARB_WRITE_REQ: begin
                    if (i_axi_aw_ready) begin
                        aw_pend <= 1'b0;
                    end
                    if (i_axi_w_ready) begin
                        w_pend <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= ARB_WRITE_RESP;
                    end
                end
                ARB_WRITE_RESP: begin
                    if (i_axi_b_valid) begin
                        o_dc_ok <= 1'b1;
                        state   <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // winner's payload, held for the whole transfer
    always_ff @(posedge clk) begin
        if (grant) begin
            if (dc_sel) begin
                req_addr  <= i_dc_addr;
                req_wdata <= i_dc_wdata;
                req_wstrb <= i_dc_wstrb;
                req_id    <= ID_DCACHE;
            end else begin
                req_addr <= i_ic_addr;
                req_id   <= ID_ICACHE;
            end
        end
        if (o_axi_r_ready && i_axi_r_valid) begin
            rsp_data <= i_axi_r_data;
        end
    end

endmodule

/* hw/mem_top.sv */
// ---------------------------------------------------------------------
// mem_top: memory side of the soc, instruction and data caches
// sharing one AXI4 master through the arbiter
// ---------------------------------------------------------------------
module mem_top
    import soc_mem_pkg::*;
#(
    parameter int ICACHE_LINES = 16,
    parameter int DCACHE_LINES = 16
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_inst_ena,
    input  addr_t              i_inst_addr,
    output logic               o_inst_valid,
    output data_t              o_inst_data,
    input  logic               i_data_re,
    input  logic               i_data_we,
    input  addr_t              i_data_addr,
    input  data_t              i_data_wdata,
    input  strb_t              i_data_wmask,
    output logic               o_data_finish,
    output data_t              o_data_rdata,
    output axi_id_t            o_axi_aw_id,
    output addr_t              o_axi_aw_addr,
    output logic [LEN_W-1:0]   o_axi_aw_len,
    output logic [SIZE_W-1:0]  o_axi_aw_size,
    output logic [BURST_W-1:0] o_axi_aw_burst,
    output logic               o_axi_aw_valid,
    input  logic               i_axi_aw_ready,
    output data_t              o_axi_w_data,
    output strb_t              o_axi_w_strb,
    output logic               o_axi_w_last,
    output logic               o_axi_w_valid,
    input  logic               i_axi_w_ready,
    input  axi_id_t            i_axi_b_id,
    input  logic [RESP_W-1:0]  i_axi_b_resp,
    input  logic               i_axi_b_valid,
    output logic               o_axi_b_ready,
    output axi_id_t            o_axi_ar_id,
    output addr_t              o_axi_ar_addr,
    output logic [LEN_W-1:0]   o_axi_ar_len,
    output logic [SIZE_W-1:0]  o_axi_ar_size,
    output logic [BURST_W-1:0] o_axi_ar_burst,
    output logic               o_axi_ar_valid,
    input  logic               i_axi_ar_ready,
    input  axi_id_t            i_axi_r_id,
    input  data_t              i_axi_r_data,
    input  logic [RESP_W-1:0]  i_axi_r_resp,
    input  logic               i_axi_r_last,
    input  logic               i_axi_r_valid,
    output logic               o_axi_r_ready
);

    logic  ic_fill_req;
    addr_t ic_fill_addr;
    data_t ic_fill_data;
    logic  ic_fill_ok;

    logic  dc_rd_req;
    logic  dc_wr_req;
    addr_t dc_addr;
    data_t dc_wdata;
    strb_t dc_wstrb;
    data_t dc_rdata;
    logic  dc_ok;

    icache #(
        .LINES(ICACHE_LINES)
    ) u_icache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_inst_ena  (i_inst_ena),
        .i_inst_addr (i_inst_addr),
        .i_fill_data (ic_fill_data),
        .i_fill_ok   (ic_fill_ok),
        .o_inst_valid(o_inst_valid),
        .o_inst_data (o_inst_data),
        .o_fill_req  (ic_fill_req),
        .o_fill_addr (ic_fill_addr)
    );

    dcache #(
        .LINES(DCACHE_LINES)
    ) u_dcache (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_re        (i_data_re),
        .i_we        (i_data_we),
        .i_addr      (i_data_addr),
        .i_wdata     (i_data_wdata),
        .i_wmask     (i_data_wmask),
        .i_mem_rdata (dc_rdata),
        .i_mem_ok    (dc_ok),
        .o_rdata     (o_data_rdata),
        .o_finish    (o_data_finish),
        .o_mem_rd_req(dc_rd_req),
        .o_mem_wr_req(dc_wr_req),
        .o_mem_addr  (dc_addr),
        .o_mem_wdata (dc_wdata),
        .o_mem_wstrb (dc_wstrb)
    );

    // axi ports carry the same names on both levels
    mem_arbiter u_arbiter (
        .i_ic_req   (ic_fill_req),
        .i_ic_addr  (ic_fill_addr),
        .o_ic_rdata (ic_fill_data),
        .o_ic_ok    (ic_fill_ok),
        .i_dc_rd_req(dc_rd_req),
        .i_dc_wr_req(dc_wr_req),
        .i_dc_addr  (dc_addr),
        .i_dc_wdata (dc_wdata),
        .i_dc_wstrb (dc_wstrb),
        .o_dc_rdata (dc_rdata),
        .o_dc_ok    (dc_ok),
        .*
    );

endmodule

/* sim/axi_mem_model.sv */
// ---------------------------------------------------------------------
// axi_mem_model: single-beat AXI4 slave memory of 256 words with
// seeded random ready and response delays
// ---------------------------------------------------------------------
module axi_mem_model
    import soc_mem_pkg::*;
(
    input  logic              clk,
    input  axi_id_t           i_aw_id,
    input  addr_t             i_aw_addr,
    input  logic              i_aw_valid,
    output logic              o_aw_ready,
    input  data_t             i_w_data,
    input  strb_t             i_w_strb,
    output logic              o_w_ready,
    output axi_id_t           o_b_id,
    output logic [RESP_W-1:0] o_b_resp,
    output logic              o_b_valid,
    input  logic              i_b_ready,
    input  axi_id_t           i_ar_id,
    input  addr_t             i_ar_addr,
    input  logic              i_ar_valid,
    output logic              o_ar_ready,
    output axi_id_t           o_r_id,
    output data_t             o_r_data,
    output logic [RESP_W-1:0] o_r_resp,
    output logic              o_r_last,
    output logic              o_r_valid,
    input  logic              i_r_ready,
    output int                o_ar_cnt_ic,
    output int                o_ar_cnt_dc,
    output axi_id_t           o_ar_last_id,
    output strb_t             o_last_wstrb
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam data_t PATTERN = 64'h5a5a_c3c3_0f0f_9696;

    int      seed;
    data_t   mem [256];
    axi_id_t cur_id;
    addr_t   cur_addr;
    data_t   cur_wdata;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // 0 to 3 idle cycles
    task automatic random_wait();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) step();
    endtask

    task automatic serve_read();
        random_wait();
        o_ar_ready = 1'b1;
        cur_id     = i_ar_id;
        cur_addr   = i_ar_addr;
        step();
        o_ar_ready = 1'b0;
        if (cur_id == ID_ICACHE) begin
            o_ar_cnt_ic++;
        end else begin
            o_ar_cnt_dc++;
        end
        o_ar_last_id = cur_id;
        random_wait();
        o_r_id    = cur_id;
        o_r_data  = mem[cur_addr[10:3]];
        o_r_last  = 1'b1;
        o_r_valid = 1'b1;
        while (!i_r_ready) step();
        step();
        o_r_valid = 1'b0;
        o_r_last  = 1'b0;
    endtask

    task automatic serve_write();
        random_wait();
        o_aw_ready = 1'b1;
        cur_id     = i_aw_id;
        cur_addr   = i_aw_addr;
        step();
        o_aw_ready = 1'b0;
        random_wait();
        o_w_ready    = 1'b1;
        cur_wdata    = i_w_data;
        o_last_wstrb = i_w_strb;
        step();
        o_w_ready = 1'b0;
        for (int b = 0; b < STRB_W; b++) begin
            if (o_last_wstrb[b]) begin
                mem[cur_addr[10:3]][b*8 +: 8] = cur_wdata[b*8 +: 8];
            end
        end
        random_wait();
        o_b_id    = cur_id;
        o_b_valid = 1'b1;
        while (!i_b_ready) step();
        step();
        o_b_valid = 1'b0;
    endtask

    initial begin
        seed = 28983;
        for (int i = 0; i < 256; i++) begin
            mem[i] = data_t'(i * 8) ^ PATTERN;
        end
        o_aw_ready   = 1'b0;
        o_w_ready    = 1'b0;
        o_b_id       = '0;
        o_b_resp     = '0;
        o_b_valid    = 1'b0;
        o_ar_ready   = 1'b0;
        o_r_id       = '0;
        o_r_data     = '0;
        o_r_resp     = '0;
        o_r_last     = 1'b0;
        o_r_valid    = 1'b0;
        o_ar_cnt_ic  = 0;
        o_ar_cnt_dc  = 0;
        o_ar_last_id = '0;
        o_last_wstrb = '0;
        forever begin
            step();
            if (i_ar_valid) begin
                serve_read();
            end else if (i_aw_valid) begin
                serve_write();
            end
        end
    end

endmodule

/* sim/tb_mem_top.sv */
// ---------------------------------------------------------------------
// tb_mem_top: acts as the cpu, runs a table of fetches, loads and
// stores and checks them against a reference memory
// ---------------------------------------------------------------------
module tb_mem_top
    import soc_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam data_t PATTERN = 64'h5a5a_c3c3_0f0f_9696;

    typedef enum {OP_FETCH, OP_LOAD, OP_STORE, OP_BOTH} op_e;
    typedef struct {
        op_e   op;
        addr_t addr;
        data_t wdata;
        strb_t mask;
        data_t exp_data;
        int    exp_ar;
    } row_t;

    logic               clk = 1'b0;
    logic               i_rst_n;
    logic               i_inst_ena, o_inst_valid;
    addr_t              i_inst_addr;
    data_t              o_inst_data;
    logic               i_data_re, i_data_we, o_data_finish;
    addr_t              i_data_addr;
    data_t              i_data_wdata, o_data_rdata;
    strb_t              i_data_wmask;
    axi_id_t            o_axi_aw_id, o_axi_ar_id, i_axi_b_id, i_axi_r_id;
    addr_t              o_axi_aw_addr, o_axi_ar_addr;
    logic [LEN_W-1:0]   o_axi_aw_len, o_axi_ar_len;
    logic [SIZE_W-1:0]  o_axi_aw_size, o_axi_ar_size;
    logic [BURST_W-1:0] o_axi_aw_burst, o_axi_ar_burst;
    logic               o_axi_aw_valid, i_axi_aw_ready, o_axi_ar_valid, i_axi_ar_ready;
    data_t              o_axi_w_data, i_axi_r_data;
    strb_t              o_axi_w_strb;
    logic               o_axi_w_last, o_axi_w_valid, i_axi_w_ready;
    logic [RESP_W-1:0]  i_axi_b_resp, i_axi_r_resp;
    logic               i_axi_b_valid, o_axi_b_ready;
    logic               i_axi_r_last, i_axi_r_valid, o_axi_r_ready;

    int      ar_cnt_ic, ar_cnt_dc;
    axi_id_t ar_last_id;
    strb_t   last_wstrb;
    data_t   ref_mem [256];
    row_t    rows[$];
    int      cycle_cnt = 0;
    int      cycle_limit = 0;
    int      checks = 0;
    int      errors = 0;

    mem_top uut (.*);

    axi_mem_model u_mem (
        .clk(clk), .i_aw_id(o_axi_aw_id), .i_aw_addr(o_axi_aw_addr),
        .i_aw_valid(o_axi_aw_valid), .o_aw_ready(i_axi_aw_ready),
        .i_w_data(o_axi_w_data), .i_w_strb(o_axi_w_strb), .o_w_ready(i_axi_w_ready),
        .o_b_id(i_axi_b_id), .o_b_resp(i_axi_b_resp), .o_b_valid(i_axi_b_valid),
        .i_b_ready(o_axi_b_ready), .i_ar_id(o_axi_ar_id), .i_ar_addr(o_axi_ar_addr),
        .i_ar_valid(o_axi_ar_valid), .o_ar_ready(i_axi_ar_ready),
        .o_r_id(i_axi_r_id), .o_r_data(i_axi_r_data), .o_r_resp(i_axi_r_resp),
        .o_r_last(i_axi_r_last), .o_r_valid(i_axi_r_valid), .i_r_ready(o_axi_r_ready),
        .o_ar_cnt_ic(ar_cnt_ic), .o_ar_cnt_dc(ar_cnt_dc),
        .o_ar_last_id(ar_last_id), .o_last_wstrb(last_wstrb)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("run timed out after %0d cycles without finishing the table", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_strb(string name, strb_t exp, strb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_field(string name, logic [7:0] exp, logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp, act);
        end
    endtask

    // single-beat attributes while a request sits on the bus
    task automatic check_bus_fields();
        if (o_axi_ar_valid) begin
            check_field("o_axi_ar_len", 8'h00, 8'(o_axi_ar_len));
            check_field("o_axi_ar_size", 8'h03, 8'(o_axi_ar_size));
            check_field("o_axi_ar_burst", 8'h01, 8'(o_axi_ar_burst));
        end
        if (o_axi_aw_valid) begin
            check_field("o_axi_aw_id", 8'(ID_DCACHE), 8'(o_axi_aw_id));
            check_field("o_axi_aw_len", 8'h00, 8'(o_axi_aw_len));
            check_field("o_axi_aw_size", 8'h03, 8'(o_axi_aw_size));
            check_field("o_axi_aw_burst", 8'h01, 8'(o_axi_aw_burst));
        end
        if (o_axi_w_valid) begin
            check_field("o_axi_w_last", 8'h01, 8'(o_axi_w_last));
        end
    endtask

    task automatic check_reset_state();
        int err_before;
        err_before = errors;
        check_field("o_inst_valid", 8'h00, 8'(o_inst_valid));
        check_field("o_data_finish", 8'h00, 8'(o_data_finish));
        check_field("o_axi_ar_valid", 8'h00, 8'(o_axi_ar_valid));
        check_field("o_axi_aw_valid", 8'h00, 8'(o_axi_aw_valid));
        check_field("o_axi_w_valid", 8'h00, 8'(o_axi_w_valid));
        check_field("o_axi_r_ready", 8'h00, 8'(o_axi_r_ready));
        check_field("o_axi_b_ready", 8'h00, 8'(o_axi_b_ready));
        $display("reset outputs: %s", (errors == err_before) ? "ok" : "error");
    endtask

    // expected word comes from the reference memory before the store lands
    function automatic void add_row(op_e op, addr_t addr, data_t wdata, strb_t mask, int exp_ar);
        int w;
        w = int'(addr[10:3]);
        rows.push_back('{op, addr, wdata, mask, ref_mem[w], exp_ar});
        if (op == OP_STORE) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mask[b]) begin
                    ref_mem[w][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endfunction

    function automatic void build_table();
        add_row(OP_FETCH, 64'h100, '0, '0, 1);
        add_row(OP_FETCH, 64'h100, '0, '0, 0);
        add_row(OP_LOAD,  64'h208, '0, '0, 1);
        add_row(OP_LOAD,  64'h208, '0, '0, 0);
        add_row(OP_STORE, 64'h208, 64'h1122_3344_5566_7788, 8'h0f, 0);
        add_row(OP_LOAD,  64'h208, '0, '0, 0);
        add_row(OP_STORE, 64'h310, 64'hdead_beef_cafe_f00d, 8'hf0, 0);
        add_row(OP_LOAD,  64'h310, '0, '0, 1);
        // same index, different tags
        add_row(OP_LOAD,  64'h040, '0, '0, 1);
        add_row(OP_LOAD,  64'h0c0, '0, '0, 1);
        add_row(OP_LOAD,  64'h040, '0, '0, 1);
        add_row(OP_LOAD,  64'h0c0, '0, '0, 1);
        add_row(OP_FETCH, 64'h040, '0, '0, 1);
        add_row(OP_FETCH, 64'h0c0, '0, '0, 1);
        add_row(OP_FETCH, 64'h040, '0, '0, 1);
        add_row(OP_BOTH,  64'h5a8, '0, '0, 1);
        add_row(OP_STORE, 64'h5a8, 64'h0102_0304_0506_0708, 8'h81, 0);
        add_row(OP_LOAD,  64'h5a8, '0, '0, 0);
        add_row(OP_STORE, 64'h400, 64'h0f1e_2d3c_4b5a_6978, 8'hff, 0);
        add_row(OP_LOAD,  64'h400, '0, '0, 1);
    endfunction

    task automatic run_row(int n, row_t r);
        int    base_ic;
        int    base_dc;
        int    lat;
        int    first_id;
        int    err_before;
        logic  inst_done;
        logic  data_done;
        data_t inst_word;
        data_t data_word;
        base_ic    = ar_cnt_ic;
        base_dc    = ar_cnt_dc;
        err_before = errors;
        lat        = 0;
        first_id   = -1;
        inst_done  = !(r.op inside {OP_FETCH, OP_BOTH});
        data_done  = (r.op == OP_FETCH);
        if (!inst_done) begin
            i_inst_ena  = 1'b1;
            i_inst_addr = r.addr;
        end
        if (!data_done) begin
            i_data_re    = (r.op != OP_STORE);
            i_data_we    = (r.op == OP_STORE);
            i_data_addr  = r.addr;
            i_data_wdata = r.wdata;
            i_data_wmask = r.mask;
        end
        while (!(inst_done && data_done)) begin
            next_cycle();
            lat++;
            check_bus_fields();
            if (!inst_done && o_inst_valid) begin
                inst_done  = 1'b1;
                inst_word  = o_inst_data;
                i_inst_ena = 1'b0;
            end
            if (!data_done && o_data_finish) begin
                data_done = 1'b1;
                data_word = o_data_rdata;
                i_data_re = 1'b0;
                i_data_we = 1'b0;
            end
            if (first_id < 0 && ar_cnt_ic + ar_cnt_dc > base_ic + base_dc) begin
                first_id = int'(ar_last_id);
            end
        end
        if (r.op inside {OP_FETCH, OP_BOTH}) begin
            check_data("o_inst_data", r.exp_data, inst_word);
            check_count("icache ar count", r.exp_ar, ar_cnt_ic - base_ic);
        end
        if (r.op inside {OP_LOAD, OP_BOTH}) begin
            check_data("o_data_rdata", r.exp_data, data_word);
        end
        if (r.op != OP_FETCH) begin
            check_count("dcache ar count", r.exp_ar, ar_cnt_dc - base_dc);
        end
        if (r.op == OP_STORE) begin
            check_strb("o_axi_w_strb", r.mask, last_wstrb);
        end
        if (r.op == OP_BOTH) begin
            check_count("first ar id", int'(ID_DCACHE), first_id);
        end
        if (r.exp_ar == 0 && r.op inside {OP_FETCH, OP_LOAD}) begin
            check_count("hit latency", 2, lat);
        end
        $display("row %0d %s addr %h: %s", n, r.op.name(), r.addr,
                 (errors == err_before) ? "ok" : "error");
        // one quiet cycle before the next request
        next_cycle();
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_inst_ena   = 1'b0;
        i_inst_addr  = '0;
        i_data_re    = 1'b0;
        i_data_we    = 1'b0;
        i_data_addr  = '0;
        i_data_wdata = '0;
        i_data_wmask = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = data_t'(i * 8) ^ PATTERN;
        end
        build_table();
        cycle_limit = 200 * rows.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        check_reset_state();
        i_rst_n = 1'b1;
        for (int n = 0; n < rows.size(); n++) begin
            run_row(n, rows[n]);
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
hw/soc_mem_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/mem_arbiter.sv
hw/mem_top.sv
sim/axi_mem_model.sv
sim/tb_mem_top.sv

/* run.sh */
#!/bin/sh
# build the memory subsystem testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --top-module tb_mem_top -f list.f -o tb_mem_top 2>&1 \
    && ./obj_dir/tb_mem_top 2>&1)
echo "$out"
echo "$out" | grep -q "^TB PASSED$" && exit 0 || exit 1
